/* id_stage.f */
+incdir+src
src/rv_isa_pkg.sv
src/id_pipe_pkg.sv
src/inst_latch.sv
src/inst_decoder.sv
src/operand_fetch.sv
src/branch_unit.sv
src/id_stage.sv
verification/tb_id_stage.sv

/* verification/id_golden.txt */
# stop valid pc inst ex_we ex_addr ex_data mem_we mem_addr mem_data
# expected: id_valid alu_op rd_we src1 src2 jump_en jump_pc link_we link_data
0 0 0 0 0 0 0 1 1 10 0 b 0 0 0 0 0 0 0
0 0 0 0 0 0 0 1 2 20 0 b 0 0 0 0 0 0 0
0 0 0 0 0 0 0 1 3 fffffffffffffff0 0 b 0 0 0 0 0 0 0
0 0 0 0 0 0 0 1 4 5 0 b 0 0 0 0 0 0 0
0 1 100 002082b3 0 0 0 0 0 0 1 0 1 10 20 0 0 0 0
0 1 104 40118333 0 0 0 0 0 0 1 1 1 fffffffffffffff0 10 0 0 0 0
0 1 108 0021a033 0 0 0 0 0 0 1 2 0 fffffffffffffff0 20 0 0 0 0
0 1 10c fff20393 0 0 0 0 0 0 1 0 1 5 0 0 0 0 0
0 1 110 4041d413 0 0 0 0 0 0 1 9 1 fffffffffffffff0 5 0 0 0 0
0 1 114 004084bb 0 0 0 0 0 0 1 0 1 10 5 0 0 0 0
0 1 118 00001537 0 0 0 0 0 0 1 a 1 0 0 0 0 0 0
0 1 11c 00001597 0 0 0 0 0 0 1 0 1 0 0 0 0 0 0
0 1 120 00208633 1 1 aa 1 1 bb 1 0 1 aa 20 0 0 0 0
0 1 124 00208633 0 0 0 1 1 cc 1 0 1 cc 20 0 0 0 0
0 1 128 00208633 0 0 0 0 0 0 1 0 1 cc 20 0 0 0 0
0 1 12c 00200633 1 0 66 1 0 55 1 0 1 0 20 0 0 0 0
1 1 130 40118333 0 0 0 0 0 0 1 0 1 0 20 0 0 0 0
1 1 130 40118333 0 0 0 0 0 0 1 0 1 0 20 0 0 0 0
0 1 130 40118333 0 0 0 0 0 0 1 1 1 fffffffffffffff0 cc 0 0 0 0
0 1 200 00110863 0 0 0 0 0 0 1 b 0 20 cc 0 0 0 0
0 1 200 00210863 0 0 0 0 0 0 1 b 0 20 20 1 210 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 200 00211863 0 0 0 0 0 0 1 b 0 20 20 0 0 0 0
0 1 200 00111863 0 0 0 0 0 0 1 b 0 20 cc 1 210 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 200 00324863 0 0 0 0 0 0 1 b 0 5 fffffffffffffff0 0 0 0 0
0 1 200 0041c863 0 0 0 0 0 0 1 b 0 fffffffffffffff0 5 1 210 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 200 0041d863 0 0 0 0 0 0 1 b 0 fffffffffffffff0 5 0 0 0 0
0 1 200 00325863 0 0 0 0 0 0 1 b 0 5 fffffffffffffff0 1 210 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 200 0041e863 0 0 0 0 0 0 1 b 0 fffffffffffffff0 5 0 0 0 0
0 1 200 00326863 0 0 0 0 0 0 1 b 0 5 fffffffffffffff0 1 210 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 200 00327863 0 0 0 0 0 0 1 b 0 5 fffffffffffffff0 0 0 0 0
0 1 200 0041f863 0 0 0 0 0 0 1 b 0 fffffffffffffff0 5 1 210 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 400 020000ef 0 0 0 0 0 0 1 b 0 0 0 1 420 1 404
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 500 004202e7 0 0 0 0 0 0 1 b 0 5 5 1 8 1 504
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0
0 1 300 002082b3 0 0 0 0 0 0 0 b 0 0 0 0 0 0 0

/* verification/tb_id_stage.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module tb_id_stage;

    localparam int NUM_VECTORS = 49;
    localparam int RESET_TIMEOUT = 50;

    logic                   clk;
    logic                   rst;
    logic                   stop_all;
    logic                   fetch_valid;
    logic [`ID_PC_W-1:0]    fetch_pc;
    logic [31:0]            fetch_inst;
    logic                   ex_we;
    logic [`ID_REG_AW-1:0]  ex_addr;
    logic [`ID_XLEN-1:0]    ex_data;
    logic                   mem_we;
    logic [`ID_REG_AW-1:0]  mem_addr;
    logic [`ID_XLEN-1:0]    mem_data;
    logic                   jump_en;
    logic [`ID_PC_W-1:0]    jump_pc;
    logic                   id_valid;
    logic [`ID_PC_W-1:0]    id_pc;
    id_pipe_pkg::alu_op_e   id_alu_op;
    id_pipe_pkg::src1_sel_e id_src1_sel;
    id_pipe_pkg::src2_sel_e id_src2_sel;
    logic                   id_word_op;
    logic [`ID_REG_AW-1:0]  id_rd;
    logic                   id_rd_we;
    logic [`ID_XLEN-1:0]    id_imm;
    logic [`ID_XLEN-1:0]    id_src1;
    logic [`ID_XLEN-1:0]    id_src2;
    logic                   link_we;
    logic [`ID_XLEN-1:0]    link_data;

    id_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_with_failure("output mismatch");
        end
    endtask

    // operand selects, word flag and immediate that the opcode calls for
    task automatic expected_decode(
        input  logic [31:0]            inst,
        output id_pipe_pkg::src1_sel_e s1,
        output id_pipe_pkg::src2_sel_e s2,
        output logic                   word,
        output logic [`ID_XLEN-1:0]    imm
    );
        logic [`ID_XLEN-1:0] i_type;
        logic [`ID_XLEN-1:0] u_type;
        logic [`ID_XLEN-1:0] b_type;
        logic [`ID_XLEN-1:0] j_type;

        i_type = $signed(inst[31:20]);
        u_type = $signed({inst[31:12], 12'h000});
        b_type = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
        j_type = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
        s1   = id_pipe_pkg::SRC1_ZERO;
        s2   = id_pipe_pkg::SRC2_ZERO;
        word = 1'b0;
        imm  = '0;
        case (inst[6:0])
            rv_isa_pkg::OPC_OP: begin
                s1 = id_pipe_pkg::SRC1_REG;
                s2 = id_pipe_pkg::SRC2_REG;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                s1  = id_pipe_pkg::SRC1_REG;
                s2  = id_pipe_pkg::SRC2_I_IMM;
                imm = i_type;
            end
            rv_isa_pkg::OPC_OP_32: begin
                s1   = id_pipe_pkg::SRC1_REG_WORD;
                s2   = id_pipe_pkg::SRC2_REG;
                word = 1'b1;
            end
            rv_isa_pkg::OPC_OP_IMM_32: begin
                s1   = id_pipe_pkg::SRC1_REG_WORD;
                s2   = id_pipe_pkg::SRC2_I_IMM;
                word = 1'b1;
                imm  = i_type;
            end
            rv_isa_pkg::OPC_LUI: begin
                s2  = id_pipe_pkg::SRC2_UPPER_IMM;
                imm = u_type;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                s1  = id_pipe_pkg::SRC1_PC;
                s2  = id_pipe_pkg::SRC2_UPPER_IMM;
                imm = u_type;
            end
            rv_isa_pkg::OPC_BRANCH: imm = b_type;
            rv_isa_pkg::OPC_JAL:    imm = j_type;
            rv_isa_pkg::OPC_JALR:   imm = i_type;
            default:                imm = '0;
        endcase
    endtask

    initial begin
        int                     fd;
        int                     n;
        int                     count;
        int                     waited;
        string                  line;
        logic [63:0]            f [19];
        logic [31:0]            exp_inst;
        logic [`ID_PC_W-1:0]    exp_pc;
        id_pipe_pkg::src1_sel_e exp_s1;
        id_pipe_pkg::src2_sel_e exp_s2;
        logic                   exp_word;
        logic [`ID_XLEN-1:0]    exp_imm;

        rst         = 1'b1;
        stop_all    = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_inst  = '0;
        ex_we       = 1'b0;
        ex_addr     = '0;
        ex_data     = '0;
        mem_we      = 1'b0;
        mem_addr    = '0;
        mem_data    = '0;
        count       = 0;
        waited      = 0;
        exp_inst    = '0;
        exp_pc      = '0;

        repeat (10) @(negedge clk);
        rst = 1'b0;
        // control outputs must come out of reset at known levels
        while ($isunknown({id_valid, jump_en, id_rd_we, link_we})) begin
            @(negedge clk);
            waited++;
            if (waited > RESET_TIMEOUT)
                stop_with_failure("outputs still unknown after reset was released");
        end

        // empty latch after reset
        check("id_valid", id_valid, 0);
        check("jump_en", jump_en, 0);
        check("id_rd_we", id_rd_we, 0);
        check("link_we", link_we, 0);

        fd = $fopen("verification/id_golden.txt", "r");
        if (fd == 0)
            stop_with_failure("golden file verification/id_golden.txt could not be opened");

        while (!$feof(fd) && count < NUM_VECTORS) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
            if (n != 19)
                stop_with_failure("golden file has a line with missing fields");

            stop_all    = f[0][0];
            fetch_valid = f[1][0];
            fetch_pc    = f[2][`ID_PC_W-1:0];
            fetch_inst  = f[3][31:0];
            ex_we       = f[4][0];
            ex_addr     = f[5][`ID_REG_AW-1:0];
            ex_data     = f[6];
            mem_we      = f[7][0];
            mem_addr    = f[8][`ID_REG_AW-1:0];
            mem_data    = f[9];

            // the latch keeps its slot while stalled, bubbles carry a zero word
            if (!f[0][0]) begin
                exp_inst = f[10][0] ? f[3][31:0] : 32'd0;
                exp_pc   = f[2][`ID_PC_W-1:0];
            end
            expected_decode(exp_inst, exp_s1, exp_s2, exp_word, exp_imm);

            // outputs of this vector settle one edge later
            @(negedge clk);
            check("id_valid", id_valid, f[10]);
            check("id_alu_op", id_alu_op, f[11]);
            check("id_rd_we", id_rd_we, f[12]);
            check("id_src1", id_src1, f[13]);
            check("id_src2", id_src2, f[14]);
            check("jump_en", jump_en, f[15]);
            if (f[15][0])
                check("jump_pc", jump_pc, f[16]);
            check("link_we", link_we, f[17]);
            if (f[17][0])
                check("link_data", link_data, f[18]);
            if (f[10][0])
                check("id_pc", id_pc, exp_pc);
            check("id_src1_sel", id_src1_sel, exp_s1);
            check("id_src2_sel", id_src2_sel, exp_s2);
            check("id_word_op", id_word_op, exp_word);
            check("id_rd", id_rd, exp_inst[11:7]);
            check("id_imm", id_imm, exp_imm);
            count++;
        end
        $fclose(fd);

        if (count != NUM_VECTORS) begin
            stop_with_failure("golden file ended before all vectors were read");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* src/id_stage.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module id_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stop_all,
    input  logic                    fetch_valid,
    input  logic [`ID_PC_W-1:0]     fetch_pc,
    input  logic [31:0]             fetch_inst,
    input  logic                    ex_we,
    input  logic [`ID_REG_AW-1:0]   ex_addr,
    input  logic [`ID_XLEN-1:0]     ex_data,
    input  logic                    mem_we,
    input  logic [`ID_REG_AW-1:0]   mem_addr,
    input  logic [`ID_XLEN-1:0]     mem_data,
    output logic                    jump_en,
    output logic [`ID_PC_W-1:0]     jump_pc,
    output logic                    id_valid,
    output logic [`ID_PC_W-1:0]     id_pc,
    output id_pipe_pkg::alu_op_e    id_alu_op,
    output id_pipe_pkg::src1_sel_e  id_src1_sel,
    output id_pipe_pkg::src2_sel_e  id_src2_sel,
    output logic                    id_word_op,
    output logic [`ID_REG_AW-1:0]   id_rd,
    output logic                    id_rd_we,
    output logic [`ID_XLEN-1:0]     id_imm,
    output logic [`ID_XLEN-1:0]     id_src1,
    output logic [`ID_XLEN-1:0]     id_src2,
    output logic                    link_we,
    output logic [`ID_XLEN-1:0]     link_data
);

    logic [31:0]             lat_inst;
    logic [`ID_REG_AW-1:0]   rs1_addr;
    logic [`ID_REG_AW-1:0]   rs2_addr;
    id_pipe_pkg::branch_op_e branch_op;

    inst_latch u_latch (
        .clk         (clk),
        .rst         (rst),
        .stop_all    (stop_all),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .jump_en     (jump_en),
        .lat_valid   (id_valid),
        .lat_pc      (id_pc),
        .lat_inst    (lat_inst)
    );

    inst_decoder u_decoder (
        .lat_valid (id_valid),
        .lat_inst  (lat_inst),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd        (id_rd),
        .rd_we     (id_rd_we),
        .alu_op    (id_alu_op),
        .src1_sel  (id_src1_sel),
        .src2_sel  (id_src2_sel),
        .word_op   (id_word_op),
        .branch_op (branch_op),
        .imm       (id_imm)
    );

    operand_fetch u_operands (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .ex_we    (ex_we),
        .ex_addr  (ex_addr),
        .ex_data  (ex_data),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .rs1_data (id_src1),
        .rs2_data (id_src2)
    );

    branch_unit u_branch (
        .lat_valid (id_valid),
        .lat_pc    (id_pc),
        .branch_op (branch_op),
        .imm       (id_imm),
        .rs1_data  (id_src1),
        .rs2_data  (id_src2),
        .rd        (id_rd),
        .jump_en   (jump_en),
        .jump_pc   (jump_pc),
        .link_we   (link_we),
        .link_data (link_data)
    );

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module branch_unit (
    input  logic                    lat_valid,
    input  logic [`ID_PC_W-1:0]     lat_pc,
    input  id_pipe_pkg::branch_op_e branch_op,
    input  logic [`ID_XLEN-1:0]     imm,
    input  logic [`ID_XLEN-1:0]     rs1_data,
    input  logic [`ID_XLEN-1:0]     rs2_data,
    input  logic [`ID_REG_AW-1:0]   rd,
    output logic                    jump_en,
    output logic [`ID_PC_W-1:0]     jump_pc,
    output logic                    link_we,
    output logic [`ID_XLEN-1:0]     link_data
);

    logic                eq;
    logic                lt_s;
    logic                lt_u;
    logic                taken;
    logic                is_jump;
    logic [`ID_PC_W-1:0] pc_target;
    logic [`ID_PC_W-1:0] reg_target;
    logic [`ID_PC_W-1:0] pc_next;

    assign eq   = (rs1_data == rs2_data);
    assign lt_s = ($signed(rs1_data) < $signed(rs2_data));
    assign lt_u = (rs1_data < rs2_data);

    always_comb begin
        case (branch_op)
            id_pipe_pkg::BR_EQ:   taken = eq;
            id_pipe_pkg::BR_NE:   taken = !eq;
            id_pipe_pkg::BR_LT:   taken = lt_s;
            id_pipe_pkg::BR_GE:   taken = !lt_s;
            id_pipe_pkg::BR_LTU:  taken = lt_u;
            id_pipe_pkg::BR_GEU:  taken = !lt_u;
            id_pipe_pkg::BR_JAL:  taken = 1'b1;
            id_pipe_pkg::BR_JALR: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    assign is_jump = (branch_op == id_pipe_pkg::BR_JAL) || (branch_op == id_pipe_pkg::BR_JALR);

    assign pc_target  = lat_pc + imm[`ID_PC_W-1:0];
    assign reg_target = rs1_data[`ID_PC_W-1:0] + imm[`ID_PC_W-1:0];

    // jalr drops bit 0 of the sum
    assign jump_pc = (branch_op == id_pipe_pkg::BR_JALR) ? {reg_target[`ID_PC_W-1:1], 1'b0}
                                                        : pc_target;
    assign jump_en = lat_valid && taken;

    assign pc_next   = lat_pc + `ID_PC_W'(`ID_LINK_OFFSET);
    assign link_data = {{(`ID_XLEN-`ID_PC_W){1'b0}}, pc_next};
    assign link_we   = lat_valid && is_jump && (rd != '0);

endmodule

/* src/operand_fetch.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module operand_fetch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ID_REG_AW-1:0] rs1_addr,
    input  logic [`ID_REG_AW-1:0] rs2_addr,
    input  logic                  ex_we,
    input  logic [`ID_REG_AW-1:0] ex_addr,
    input  logic [`ID_XLEN-1:0]   ex_data,
    input  logic                  mem_we,
    input  logic [`ID_REG_AW-1:0] mem_addr,
    input  logic [`ID_XLEN-1:0]   mem_data,
    output logic [`ID_XLEN-1:0]   rs1_data,
    output logic [`ID_XLEN-1:0]   rs2_data
);

    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

    // youngest producer wins, x0 is never forwarded
    function automatic logic [`ID_XLEN-1:0] read_port(input logic [`ID_REG_AW-1:0] addr);
        if (addr == '0)
            return '0;
        else if (ex_we && ex_addr == addr)
            return ex_data;
        else if (mem_we && mem_addr == addr)
            return mem_data;
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ID_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (mem_we && mem_addr != '0) begin
            regs[mem_addr] <= mem_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // a write aimed at x0 leaves every entry alone
    for (genvar g = 0; g < `ID_NUM_REGS; g++) begin : g_x0_check
        a_x0_untouched: assert property (
            @(posedge clk) disable iff (rst)
            (mem_we && mem_addr == '0) |=> $stable(regs[g])
        );
    end

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module inst_decoder (
    input  logic                       lat_valid,
    input  logic [31:0]                lat_inst,
    output logic [`ID_REG_AW-1:0]      rs1_addr,
    output logic [`ID_REG_AW-1:0]      rs2_addr,
    output logic [`ID_REG_AW-1:0]      rd,
    output logic                       rd_we,
    output id_pipe_pkg::alu_op_e       alu_op,
    output id_pipe_pkg::src1_sel_e     src1_sel,
    output id_pipe_pkg::src2_sel_e     src2_sel,
    output logic                       word_op,
    output id_pipe_pkg::branch_op_e    branch_op,
    output logic [`ID_XLEN-1:0]        imm
);

    logic [6:0]          funct7;
    logic [2:0]          funct3;
    logic [`ID_XLEN-1:0] imm_i;
    logic [`ID_XLEN-1:0] imm_u;
    logic [`ID_XLEN-1:0] imm_b;
    logic [`ID_XLEN-1:0] imm_j;
    logic                reg_f7_ok;
    logic                shift_f7_ok;
    logic                word_f3_ok;
    logic                writes;

    function automatic id_pipe_pkg::alu_op_e alu_map(input logic [2:0] f3, input logic alt);
        case (rv_isa_pkg::alu_f3_e'(f3))
            rv_isa_pkg::F3_ADD_SUB: alu_map = alt ? id_pipe_pkg::ALU_SUB : id_pipe_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     alu_map = id_pipe_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     alu_map = id_pipe_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    alu_map = id_pipe_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     alu_map = id_pipe_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: alu_map = alt ? id_pipe_pkg::ALU_SRA : id_pipe_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      alu_map = id_pipe_pkg::ALU_OR;
            default:                alu_map = id_pipe_pkg::ALU_AND;
        endcase
    endfunction

    assign rs1_addr = lat_inst[19:15];
    assign rs2_addr = lat_inst[24:20];
    assign rd       = lat_inst[11:7];
    assign funct3   = lat_inst[14:12];
    assign funct7   = lat_inst[31:25];

    assign imm_i = {{(`ID_XLEN-12){lat_inst[31]}}, lat_inst[31:20]};
    assign imm_u = {{(`ID_XLEN-32){lat_inst[31]}}, lat_inst[31:12], 12'b0};
    assign imm_b = {{(`ID_XLEN-13){lat_inst[31]}}, lat_inst[31], lat_inst[7],
                    lat_inst[30:25], lat_inst[11:8], 1'b0};
    assign imm_j = {{(`ID_XLEN-21){lat_inst[31]}}, lat_inst[31], lat_inst[19:12],
                    lat_inst[20], lat_inst[30:21], 1'b0};

    // alt funct7 only legal on add/sub and the right shifts
    assign reg_f7_ok = (funct7 == 7'd0) ||
                       ((funct7 == rv_isa_pkg::FUNCT7_ALT) &&
                        (funct3 == rv_isa_pkg::F3_ADD_SUB || funct3 == rv_isa_pkg::F3_SRL_SRA));

    // 64-bit shift amounts borrow funct7 bit 0
    assign shift_f7_ok = (funct3 == rv_isa_pkg::F3_SLL) ? (funct7[6:1] == 6'd0) :
                         (funct3 == rv_isa_pkg::F3_SRL_SRA) ?
                             (funct7[6:1] == 6'd0 ||
                              funct7[6:1] == rv_isa_pkg::FUNCT7_ALT[6:1]) :
                         1'b1;

    assign word_f3_ok = (funct3 == rv_isa_pkg::F3_ADD_SUB) ||
                        (funct3 == rv_isa_pkg::F3_SLL) ||
                        (funct3 == rv_isa_pkg::F3_SRL_SRA);

    always_comb begin
        alu_op    = id_pipe_pkg::ALU_NONE;
        src1_sel  = id_pipe_pkg::SRC1_ZERO;
        src2_sel  = id_pipe_pkg::SRC2_ZERO;
        word_op   = 1'b0;
        branch_op = id_pipe_pkg::BR_NONE;
        writes    = 1'b0;
        imm       = '0;
        case (rv_isa_pkg::opcode_e'(lat_inst[6:0]))
            rv_isa_pkg::OPC_OP: begin
                if (reg_f7_ok) begin
                    alu_op   = alu_map(funct3, funct7[5]);
                    src1_sel = id_pipe_pkg::SRC1_REG;
                    src2_sel = id_pipe_pkg::SRC2_REG;
                    writes   = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                if (shift_f7_ok) begin
                    alu_op   = alu_map(funct3, funct3 == rv_isa_pkg::F3_SRL_SRA && funct7[5]);
                    src1_sel = id_pipe_pkg::SRC1_REG;
                    src2_sel = id_pipe_pkg::SRC2_I_IMM;
                    imm      = imm_i;
                    writes   = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP_32: begin
                if (word_f3_ok && reg_f7_ok) begin
                    alu_op   = alu_map(funct3, funct7[5]);
                    src1_sel = id_pipe_pkg::SRC1_REG_WORD;
                    src2_sel = id_pipe_pkg::SRC2_REG;
                    word_op  = 1'b1;
                    writes   = 1'b1;
                end
            end
            rv_isa_pkg::OPC_OP_IMM_32: begin
                // addiw takes any upper bits, the shifts do not
                if (word_f3_ok && (funct3 == rv_isa_pkg::F3_ADD_SUB || reg_f7_ok)) begin
                    alu_op   = alu_map(funct3, funct3 == rv_isa_pkg::F3_SRL_SRA && funct7[5]);
                    src1_sel = id_pipe_pkg::SRC1_REG_WORD;
                    src2_sel = id_pipe_pkg::SRC2_I_IMM;
                    imm      = imm_i;
                    word_op  = 1'b1;
                    writes   = 1'b1;
                end
            end
            rv_isa_pkg::OPC_LUI: begin
                alu_op   = id_pipe_pkg::ALU_LUI;
                src2_sel = id_pipe_pkg::SRC2_UPPER_IMM;
                imm      = imm_u;
                writes   = 1'b1;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                alu_op   = id_pipe_pkg::ALU_ADD;
                src1_sel = id_pipe_pkg::SRC1_PC;
                src2_sel = id_pipe_pkg::SRC2_UPPER_IMM;
                imm      = imm_u;
                writes   = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                imm = imm_b;
                case (rv_isa_pkg::branch_f3_e'(funct3))
                    rv_isa_pkg::F3_BEQ:  branch_op = id_pipe_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE:  branch_op = id_pipe_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT:  branch_op = id_pipe_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE:  branch_op = id_pipe_pkg::BR_GE;
                    rv_isa_pkg::F3_BLTU: branch_op = id_pipe_pkg::BR_LTU;
                    rv_isa_pkg::F3_BGEU: branch_op = id_pipe_pkg::BR_GEU;
                    default:             branch_op = id_pipe_pkg::BR_NONE;
                endcase
            end
            rv_isa_pkg::OPC_JAL: begin
                branch_op = id_pipe_pkg::BR_JAL;
                imm       = imm_j;
            end
            rv_isa_pkg::OPC_JALR: begin
                if (funct3 == 3'd0) begin
                    branch_op = id_pipe_pkg::BR_JALR;
                    imm       = imm_i;
                end
            end
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    // x0 destinations are dropped here
    assign rd_we = writes && lat_valid && (rd != '0);

endmodule

/* src/inst_latch.sv */
`timescale 1ns/1ns
`include "id_settings.svh"

module inst_latch (
    input  logic               clk,
    input  logic               rst,
    input  logic               stop_all,
    input  logic               fetch_valid,
    input  logic [`ID_PC_W-1:0] fetch_pc,
    input  logic [31:0]        fetch_inst,
    input  logic               jump_en,
    output logic               lat_valid,
    output logic [`ID_PC_W-1:0] lat_pc,
    output logic [31:0]        lat_inst
);

    // set for one cycle after a redirect
    logic shadow;

    always_ff @(posedge clk) begin
        if (rst) begin
            lat_valid <= 1'b0;
            lat_pc    <= '0;
            lat_inst  <= '0;
            shadow    <= 1'b0;
        end else if (!stop_all) begin
            shadow <= jump_en;
            if (jump_en || shadow) begin
                // wrong-path slot becomes a bubble
                lat_valid <= 1'b0;
                lat_inst  <= '0;
            end else begin
                lat_valid <= fetch_valid;
                lat_pc    <= fetch_pc;
                lat_inst  <= fetch_valid ? fetch_inst : 32'd0;
            end
        end
    end

    // the slot after a taken redirect never carries work
    a_bubble_after_jump: assert property (
        @(posedge clk) disable iff (rst)
        (jump_en && !stop_all) |=> !lat_valid
    );

endmodule

/* src/id_pipe_pkg.sv */
package id_pipe_pkg;

    // operation for the execute alu
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_LUI  = 4'd10,
        ALU_NONE = 4'd11
    } alu_op_e;

    // nine kinds, so one bit wider than a funct3
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_EQ   = 4'd1,
        BR_NE   = 4'd2,
        BR_LT   = 4'd3,
        BR_GE   = 4'd4,
        BR_LTU  = 4'd5,
        BR_GEU  = 4'd6,
        BR_JAL  = 4'd7,
        BR_JALR = 4'd8
    } branch_op_e;

    typedef enum logic [1:0] {
        SRC1_ZERO     = 2'd0,
        SRC1_PC       = 2'd1,
        SRC1_REG      = 2'd2,
        SRC1_REG_WORD = 2'd3
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_ZERO      = 2'd0,
        SRC2_UPPER_IMM = 2'd1,
        SRC2_I_IMM     = 2'd2,
        SRC2_REG       = 2'd3
    } src2_sel_e;

endpackage

/* src/rv_isa_pkg.sv */
package rv_isa_pkg;

    // major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_OP        = 7'b0110011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_OP_32     = 7'b0111011,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_BRANCH    = 7'b1100011,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111
    } opcode_e;

    // conditional branch funct3
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    // integer alu funct3
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    // funct7 of sub and sra
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

endpackage

/* src/id_settings.svh */
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// data path width
`define ID_XLEN 64

// instruction address width
`define ID_PC_W 32

// register file shape
`define ID_REG_AW 5
`define ID_NUM_REGS 32

// pc step to the next instruction
`define ID_LINK_OFFSET 4

`endif
